/* Bender.yml */
package:
  name: accel_core

sources:
  - source/accel_core_pkg.sv
  - source/accel_core_stream_reg.sv
  - source/accel_core_operand_store.sv
  - source/accel_core_mul_controller.sv
  - source/accel_core_mac.sv
  - source/accel_core_result_collector.sv
  - source/accel_core_mul_top.sv
  - target: simulation
    files:
      - sim/tb_accel_core.sv

/* flist.f */
source/accel_core_pkg.sv
source/accel_core_stream_reg.sv
source/accel_core_operand_store.sv
source/accel_core_mul_controller.sv
source/accel_core_mac.sv
source/accel_core_result_collector.sv
source/accel_core_mul_top.sv
sim/tb_accel_core.sv

/* sim/tb_accel_core.sv */
`timescale 1ns/10ps

module tb_accel_core
    import accel_core_pkg::*;
();

    localparam int N_PHASE   = 2;
    localparam int TIMEOUT   = 200;   // cycles per handshake.
    localparam int RX_LIMIT  = 1000;  // cycles for a whole layer of results.
    localparam int STALL_MIN = 8;     // cycles of w_ready low that count as a stall.

    logic                 Clock;
    logic                 rst_n;
    logic                 x_valid;
    logic                 x_ready;
    t_elem [N_IN-1:0]     x_data;
    logic                 w_valid;
    logic                 w_ready;
    t_weight_rec          w_data;
    logic                 r_valid;
    logic                 r_ready;
    t_result_rec          r_data;
    t_elem [N_NEURON-1:0] out_vector;

    // ========================================
    // stimulus table, one row per vector
    // ========================================
    t_elem [N_IN-1:0] tab_x [N_PHASE] = '{32'h14F10721, 32'h7F7F807F};
    t_weight_rec tab_w [N_PHASE][N_NEURON] = '{
        '{{3'd5, 32'h10E030F8}, {3'd2, 32'hFF40C012}, {3'd7, 32'h3A05D37F},
          {3'd0, 32'h802211F0}, {3'd3, 32'h01020304}, {3'd6, 32'hC8C83838},
          {3'd1, 32'h00000000}, {3'd4, 32'h7F807F80}},
        // overflow both ways, plus a few in range.
        '{{3'd3, 32'h7F7F807F}, {3'd0, 32'h80807F80}, {3'd6, 32'h01020304},
          {3'd1, 32'h4040C040}, {3'd7, 32'h02FE0103}, {3'd2, 32'hC0C040C0},
          {3'd5, 32'hFFFFFFFF}, {3'd4, 32'h00000001}}
    };
    bit tab_hold [N_PHASE] = '{1'b0, 1'b1};  // hold r_ready low at the start.

    t_elem exp_val [N_NEURON];
    bit    seen [N_NEURON];
    int    n_rx;
    int    n_acc;
    bit    hold_r;

    accel_core_mul_top u_accel_core_mul_top (
        .Clock(Clock), .rst_n(rst_n),
        .x_valid(x_valid), .x_ready(x_ready), .x_data(x_data),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data),
        .out_vector(out_vector)
    );

    always #10 Clock = ~Clock;

    always @(posedge Clock) begin
        r_ready = #2 (hold_r ? 1'b0 : (($urandom % 4) != 0));  // gaps on the result side.
    end

    always @(posedge Clock) begin
        if (rst_n && r_valid && r_ready) check_result(r_data);
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    // dot product, arithmetic shift, then clamp to 8 bits.
    function automatic t_elem expected_value(input t_elem [N_IN-1:0] x, input t_weight_rec w);
        int    sum;
        t_elem res;
        sum = 0;
        for (int i = 0; i < N_IN; i++) sum += int'(x[i]) * int'(w.weights[i]);
        sum = sum >>> FRAC_BITS;
        if (sum > 127) res = 8'sd127;
        else if (sum < -128) res = -8'sd128;
        else res = t_elem'(sum);
        return res;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %s: got %h expected %h", name, got, want);
            stop_run();
        end
    endtask

    task automatic check_result(input t_result_rec got);
        if (seen[got.idx]) begin
            $display("neuron index %0d arrived twice on r_data", got.idx);
            stop_run();
        end
        if (got.value !== exp_val[got.idx]) begin
            $display("FAIL r_data.value idx %h: got %h expected %h",
                     got.idx, got.value, exp_val[got.idx]);
            stop_run();
        end
        seen[got.idx] = 1'b1;
        n_rx++;
    endtask

    task automatic check_vector(input int idx, input t_elem got, input t_elem want);
        if (got !== want) begin
            $display("FAIL out_vector[%0d]: got %h expected %h", idx, got, want);
            stop_run();
        end
    endtask

    task automatic send_vector(input t_elem [N_IN-1:0] x);
        int cnt;
        bit done;
        x_valid = 1'b1;
        x_data  = x;
        cnt     = 0;
        done    = 1'b0;
        while (!done) begin
            @(posedge Clock);
            done = x_ready;
            cnt++;
            if (!done && cnt > TIMEOUT) begin
                $display("timeout while waiting for x_ready to accept a vector");
                stop_run();
            end
        end
        #2 x_valid = 1'b0;
    endtask

    task automatic send_records(input int ph);
        int cnt;
        int gap;
        bit done;
        for (int i = 0; i < N_NEURON; i++) begin
            gap     = $urandom % 3;
            w_valid = 1'b0;
            repeat (gap) begin
                @(posedge Clock);
                #2;
            end
            w_valid = 1'b1;
            w_data  = tab_w[ph][i];
            cnt     = 0;
            done    = 1'b0;
            while (!done) begin
                @(posedge Clock);
                done = w_ready;
                cnt++;
                if (!done && cnt > TIMEOUT) begin
                    $display("timeout while waiting for w_ready to accept a record");
                    stop_run();
                end
            end
            n_acc++;
            #2;
        end
        w_valid = 1'b0;
    endtask

    task automatic wait_results();
        int cnt;
        cnt = 0;
        while (n_rx < N_NEURON) begin
            @(negedge Clock);
            cnt++;
            if (cnt > RX_LIMIT) begin
                $display("timeout while waiting for all results of a vector");
                stop_run();
            end
        end
    endtask

    // three slots plus one record in each register slice.
    task automatic release_after_stall();
        int cnt;
        int stall;
        cnt   = 0;
        stall = 0;
        while (stall < STALL_MIN) begin
            @(posedge Clock);
            if (w_valid && !w_ready) stall++;
            else stall = 0;
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("w_ready never fell while r_ready was held low");
                stop_run();
            end
        end
        if (n_acc > N_SLOT + 2) begin
            $display("FAIL w_ready accepted records: got %h limit %h", n_acc, N_SLOT + 2);
            stop_run();
        end
        #2 hold_r = 1'b0;
    endtask

    task automatic run_phase(input int ph);
        for (int i = 0; i < N_NEURON; i++) begin
            exp_val[tab_w[ph][i].idx] = expected_value(tab_x[ph], tab_w[ph][i]);
            seen[i] = 1'b0;
        end
        n_rx   = 0;
        n_acc  = 0;
        hold_r = tab_hold[ph];
        send_vector(tab_x[ph]);
        fork
            send_records(ph);
            wait_results();
            begin
                if (tab_hold[ph]) release_after_stall();
            end
        join
        @(negedge Clock);
        for (int i = 0; i < N_NEURON; i++) check_vector(i, out_vector[i], exp_val[i]);
        @(posedge Clock);
        #2;
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        void'($urandom(32'heb79bfa1));
        Clock   = 1'b0;
        rst_n   = 1'b0;
        x_valid = 1'b0;
        x_data  = '0;
        w_valid = 1'b0;
        w_data  = '0;
        r_ready = 1'b0;
        hold_r  = 1'b0;
        repeat (8) @(posedge Clock);
        #2 rst_n = 1'b1;
        @(negedge Clock);
        check_flag("r_valid", r_valid, 1'b0);
        check_flag("x_ready", x_ready, 1'b1);
        @(posedge Clock);
        #2;
        for (int ph = 0; ph < N_PHASE; ph++) run_phase(ph);
        $display("Verification passed");
        $finish;
    end

endmodule

/* source/accel_core_mac.sv */
`timescale 1ns/10ps

module accel_core_mac
    import accel_core_pkg::*;
#(
    parameter int N_IN      = accel_core_pkg::N_IN,
    parameter int FRAC_BITS = accel_core_pkg::FRAC_BITS
) (
    input  logic             Clock,
    input  logic             rst_n,
    input  logic             start,
    input  t_elem [N_IN-1:0] x_vec,
    input  t_weight_rec      weights,
    input  logic             take,
    output logic             busy,
    output logic             done,
    output t_result_rec      result
);

    localparam int ACC_W = 16 + $clog2(N_IN) + 1;  // room for every product sum.
    localparam int CNT_W = (N_IN > 1) ? $clog2(N_IN) : 1;

    typedef enum logic [1:0] {IDLE, ACC, SAT, HOLD} t_state;

    t_state                   state;
    logic [CNT_W-1:0]         cnt;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  shifted;
    logic signed [15:0]       prod;
    t_elem                    sat;

    assign busy = (state != IDLE);
    assign done = (state == HOLD);

    always_comb begin
        prod    = x_vec[cnt] * weights.weights[cnt];
        shifted = acc >>> FRAC_BITS;
        if (shifted > 127) sat = 8'sd127;
        else if (shifted < -128) sat = -8'sd128;
        else sat = shifted[7:0];
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state <= ACC;
                    cnt   <= '0;
                end
                ACC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(N_IN - 1)) state <= SAT;  // last element pair.
                end
                SAT:  state <= HOLD;
                HOLD: if (take) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == IDLE && start) acc <= '0;
        else if (state == ACC) acc <= acc + prod;
        if (state == SAT) begin
            result.idx   <= weights.idx;
            result.value <= sat;  // held until the collector takes it.
        end
    end

    a_start_idle: assert property (@(posedge Clock) disable iff (!rst_n)
        start |-> !busy)
        else $error("mac: start while busy.");

endmodule

/* source/accel_core_mul_controller.sv */
`timescale 1ns/10ps

module accel_core_mul_controller
    import accel_core_pkg::*;
(
    input  logic              Clock,
    input  logic              rst_n,
    input  logic [N_SLOT-1:0] slot_used,
    input  logic [N_SLOT-1:0] slot_assigned,
    input  logic              busy_m1,
    input  logic              busy_m2,
    output logic [N_SLOT-1:0] claim,
    output logic              start_m1,
    output logic              start_m2,
    output t_slot_sel         assign_m1,
    output t_slot_sel         assign_m2,
    output logic              units_idle
);

    logic              idle_m1;
    logic              idle_m2;
    logic [N_SLOT-1:0] pending;
    logic [N_SLOT-1:0] pending_m2;
    t_slot_sel         pick_m1;
    t_slot_sel         pick_m2;

    function automatic t_slot_sel lowest_slot(input logic [N_SLOT-1:0] mask);
        t_slot_sel sel;
        sel = NONE;
        for (int i = N_SLOT - 1; i >= 0; i--) begin
            if (mask[i]) sel = t_slot_sel'(i);
        end
        return sel;
    endfunction

    // a unit is idle from its slot release until the next assignment.
    assign idle_m1    = (assign_m1 == NONE) && !busy_m1;
    assign idle_m2    = (assign_m2 == NONE) && !busy_m2;
    assign units_idle = idle_m1 && idle_m2 && !(|slot_used);

    always_comb begin
        pending    = slot_used & ~slot_assigned;
        pick_m1    = idle_m1 ? lowest_slot(pending) : NONE;
        pending_m2 = pending;
        if (pick_m1 != NONE) pending_m2[pick_m1] = 1'b0;  // m1 has priority.
        pick_m2    = idle_m2 ? lowest_slot(pending_m2) : NONE;
        claim      = '0;
        if (pick_m1 != NONE) claim[pick_m1] = 1'b1;
        if (pick_m2 != NONE) claim[pick_m2] = 1'b1;
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            start_m1  <= 1'b0;
            start_m2  <= 1'b0;
            assign_m1 <= NONE;
            assign_m2 <= NONE;
        end else begin
            start_m1 <= (pick_m1 != NONE);
            start_m2 <= (pick_m2 != NONE);
            if (pick_m1 != NONE) assign_m1 <= pick_m1;
            else if (assign_m1 != NONE && !slot_used[assign_m1]) assign_m1 <= NONE;
            if (pick_m2 != NONE) assign_m2 <= pick_m2;
            else if (assign_m2 != NONE && !slot_used[assign_m2]) assign_m2 <= NONE;
        end
    end

    a_no_shared_slot: assert property (@(posedge Clock) disable iff (!rst_n)
        (assign_m1 == NONE) || (assign_m1 != assign_m2))
        else $error("mul_controller: both units on one slot.");

endmodule

/* source/accel_core_mul_top.sv */
`timescale 1ns/10ps

module accel_core_mul_top
    import accel_core_pkg::*;
#(
    parameter int N_IN      = accel_core_pkg::N_IN,
    parameter int FRAC_BITS = accel_core_pkg::FRAC_BITS
) (
    input  logic                 Clock,
    input  logic                 rst_n,
    input  logic                 x_valid,
    output logic                 x_ready,
    input  t_elem [N_IN-1:0]     x_data,
    input  logic                 w_valid,
    output logic                 w_ready,
    input  t_weight_rec          w_data,
    output logic                 r_valid,
    input  logic                 r_ready,
    output t_result_rec          r_data,
    output t_elem [N_NEURON-1:0] out_vector
);

    logic              ws_valid, ws_ready;
    t_weight_rec       ws_data;
    logic [N_SLOT-1:0] slot_used, slot_assigned, claim;
    logic              start_m1, start_m2, units_idle;
    t_slot_sel         assign_m1, assign_m2;
    t_elem [N_IN-1:0]  x_vec;
    t_weight_rec       weight_m1, weight_m2;
    logic              busy_m1, busy_m2, done_m1, done_m2;
    t_result_rec       result_m1, result_m2;
    logic              take_m1, take_m2;
    logic              rs_valid, rs_ready;
    t_result_rec       rs_data;

    // ========================================
    // input side
    // ========================================
    accel_core_stream_reg #(.t_payload(t_weight_rec)) u_w_reg (
        .Clock(Clock), .rst_n(rst_n),
        .in_valid(w_valid), .in_ready(w_ready), .in_data(w_data),
        .out_valid(ws_valid), .out_ready(ws_ready), .out_data(ws_data)
    );

    accel_core_operand_store #(.N_IN(N_IN)) u_operand_store (
        .Clock(Clock), .rst_n(rst_n),
        .x_valid(x_valid), .x_ready(x_ready), .x_data(x_data),
        .w_valid(ws_valid), .w_ready(ws_ready), .w_data(ws_data),
        .units_idle(units_idle), .claim(claim),
        .release_m1(take_m1), .release_m2(take_m2),  // release is the take pulse.
        .assign_m1(assign_m1), .assign_m2(assign_m2),
        .slot_used(slot_used), .slot_assigned(slot_assigned),
        .x_vec(x_vec), .weight_m1(weight_m1), .weight_m2(weight_m2)
    );

    // ========================================
    // processing
    // ========================================
    accel_core_mul_controller u_mul_controller (
        .Clock(Clock), .rst_n(rst_n),
        .slot_used(slot_used), .slot_assigned(slot_assigned),
        .busy_m1(busy_m1), .busy_m2(busy_m2), .claim(claim),
        .start_m1(start_m1), .start_m2(start_m2),
        .assign_m1(assign_m1), .assign_m2(assign_m2), .units_idle(units_idle)
    );

    accel_core_mac #(.N_IN(N_IN), .FRAC_BITS(FRAC_BITS)) u_mac_m1 (
        .Clock(Clock), .rst_n(rst_n), .start(start_m1), .x_vec(x_vec),
        .weights(weight_m1), .take(take_m1),
        .busy(busy_m1), .done(done_m1), .result(result_m1)
    );

    accel_core_mac #(.N_IN(N_IN), .FRAC_BITS(FRAC_BITS)) u_mac_m2 (
        .Clock(Clock), .rst_n(rst_n), .start(start_m2), .x_vec(x_vec),
        .weights(weight_m2), .take(take_m2),
        .busy(busy_m2), .done(done_m2), .result(result_m2)
    );

    // ========================================
    // output side
    // ========================================
    accel_core_result_collector u_result_collector (
        .Clock(Clock), .rst_n(rst_n),
        .done_m1(done_m1), .result_m1(result_m1),
        .done_m2(done_m2), .result_m2(result_m2),
        .out_ready(rs_ready), .take_m1(take_m1), .take_m2(take_m2),
        .out_valid(rs_valid), .out_data(rs_data), .out_vector(out_vector)
    );

    accel_core_stream_reg #(.t_payload(t_result_rec)) u_r_reg (
        .Clock(Clock), .rst_n(rst_n),
        .in_valid(rs_valid), .in_ready(rs_ready), .in_data(rs_data),
        .out_valid(r_valid), .out_ready(r_ready), .out_data(r_data)
    );

endmodule

/* source/accel_core_operand_store.sv */
`timescale 1ns/10ps

module accel_core_operand_store
    import accel_core_pkg::*;
#(
    parameter int N_IN = accel_core_pkg::N_IN
) (
    input  logic              Clock,
    input  logic              rst_n,
    input  logic              x_valid,
    output logic              x_ready,
    input  t_elem [N_IN-1:0]  x_data,
    input  logic              w_valid,
    output logic              w_ready,
    input  t_weight_rec       w_data,
    input  logic              units_idle,
    input  logic [N_SLOT-1:0] claim,
    input  logic              release_m1,
    input  logic              release_m2,
    input  t_slot_sel         assign_m1,
    input  t_slot_sel         assign_m2,
    output logic [N_SLOT-1:0] slot_used,
    output logic [N_SLOT-1:0] slot_assigned,
    output t_elem [N_IN-1:0]  x_vec,
    output t_weight_rec       weight_m1,
    output t_weight_rec       weight_m2
);

    t_weight_rec       slot_q [N_SLOT];
    logic [N_SLOT-1:0] fill;
    logic [N_SLOT-1:0] rel_mask;
    logic              w_fire;

    assign x_ready = units_idle;  // vector only swaps with nothing in flight.
    assign w_ready = !(&slot_used);
    assign w_fire  = w_valid && w_ready;

    always_comb begin
        fill     = '0;
        rel_mask = '0;
        for (int i = 0; i < N_SLOT; i++) begin
            if (!slot_used[i] && fill == '0) fill[i] = 1'b1;  // lowest free slot.
        end
        if (release_m1 && assign_m1 != NONE) rel_mask[assign_m1] = 1'b1;
        if (release_m2 && assign_m2 != NONE) rel_mask[assign_m2] = 1'b1;
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            slot_used     <= '0;
            slot_assigned <= '0;
        end else begin
            slot_used     <= (slot_used & ~rel_mask) | (fill & {N_SLOT{w_fire}});
            slot_assigned <= (slot_assigned | claim) & ~rel_mask;
        end
    end

    always_ff @(posedge Clock) begin
        if (x_valid && x_ready) x_vec <= x_data;
        for (int i = 0; i < N_SLOT; i++) begin
            if (w_fire && fill[i]) slot_q[i] <= w_data;
        end
    end

    // ========================================
    // weight multiplexer towards the units
    // ========================================
    always_comb begin
        weight_m1 = (assign_m1 != NONE) ? slot_q[assign_m1] : '0;
        weight_m2 = (assign_m2 != NONE) ? slot_q[assign_m2] : '0;
    end

    a_release_used: assert property (@(posedge Clock) disable iff (!rst_n)
        (release_m1 || release_m2) |-> (rel_mask & ~slot_used) == '0)
        else $error("operand_store: release of a slot not in use.");

endmodule

/* source/accel_core_pkg.sv */
package accel_core_pkg;

    // ========================================
    // layer dimensions
    // ========================================
    localparam int N_IN      = 4;  // elements per input vector.
    localparam int N_NEURON  = 8;  // neurons per layer.
    localparam int FRAC_BITS = 4;  // fixed point shift after accumulation.
    localparam int N_SLOT    = 3;  // weight slots.

    // ========================================
    // element and record types
    // ========================================
    typedef logic signed [7:0] t_elem;
    typedef logic [$clog2(N_NEURON)-1:0] t_neuron_idx;

    typedef enum logic [1:0] {
        W1   = 2'd0,
        W2   = 2'd1,
        W3   = 2'd2,
        NONE = 2'd3
    } t_slot_sel;

    // one neuron's index and weights (35 bits).
    typedef struct packed {
        t_neuron_idx      idx;
        t_elem [N_IN-1:0] weights;
    } t_weight_rec;

    typedef struct packed {
        t_neuron_idx idx;   // neuron the value belongs to.
        t_elem       value;
    } t_result_rec;

endpackage

/* source/accel_core_result_collector.sv */
`timescale 1ns/10ps

module accel_core_result_collector
    import accel_core_pkg::*;
(
    input  logic                 Clock,
    input  logic                 rst_n,
    input  logic                 done_m1,
    input  t_result_rec          result_m1,
    input  logic                 done_m2,
    input  t_result_rec          result_m2,
    input  logic                 out_ready,
    output logic                 take_m1,
    output logic                 take_m2,
    output logic                 out_valid,
    output t_result_rec          out_data,
    output t_elem [N_NEURON-1:0] out_vector
);

    // m1 wins when both are done.
    assign out_valid = done_m1 || done_m2;
    assign out_data  = done_m1 ? result_m1 : result_m2;
    assign take_m1   = done_m1 && out_ready;
    assign take_m2   = done_m2 && !done_m1 && out_ready;

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            out_vector <= '0;
        end else if (take_m1 || take_m2) begin
            out_vector[out_data.idx] <= out_data.value;  // same edge as the release.
        end
    end

endmodule

/* source/accel_core_stream_reg.sv */
`timescale 1ns/10ps

module accel_core_stream_reg #(
    parameter type t_payload = logic
) (
    input  logic     Clock,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  t_payload in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output t_payload out_data
);

    logic in_fire;

    // free now, or emptied on this edge.
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge Clock) begin
        if (in_fire) begin
            out_data <= in_data;  // captured on an accepted transfer.
        end
    end

    // a stalled datum must not change under the consumer.
    property p_hold_stable;
        @(posedge Clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
    endproperty

    a_hold_stable: assert property (p_hold_stable)
        else $error("stream_reg: out_data changed while stalled.");

endmodule
